/* build.f */
demodPkg.sv
demodRegs.sv
resetSequencer.sv
cycleCounter.sv
symbolRouter.sv
dacOutputStage.sv
demodTop.sv
tbClockGen.sv
demodTb.sv

/* runSim.sh */
#!/bin/sh
# Compile the demodulator testbench with Verilator and run it.
# The exit status is nonzero when the build or the simulation fails.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f build.f --top-module demodTb -o demodSim &&
./obj_dir/demodSim ||
{ echo "simulation failed"; exit 1; }

/* demodTb.sv */
/*
 * Testbench for the demodulator glue top level.
 * Checks the register space, counter, soft reset, reboot request and a
 * table of routing and DAC rows built from seeded random data.
 */

`timescale 1ns/1ns

module demodTb;

    import demodPkg::*;

    localparam int numRows   = 20;
    localparam int waitLimit = 40;

    typedef struct packed {
        demodModeT                   mode;
        legacySymT                   legacy;
        multihSymT                   multih;
        logic                        carrierLock;
        logic                        multihLock;
        dacSampleT [dacChannels-1:0] legacyDac;
        dacSampleT [dacChannels-1:0] multihDac;
        trellisOutT                  expTrellis;
        dataOutT                     expData;
        logic                        expNLock;
        logic [dacChannels-1:0]      expSync;
        dacWordT [dacChannels-1:0]   expPins;
    } stimRowT;

    logic                        clk;
    logic                        clockCounterEn;
    busAddrT                     busAddr;
    busDataT                     busWrData;
    logic                        busWr;
    busDataT                     busRdData;
    legacySymT                   legacy;
    multihSymT                   multih;
    logic                        carrierLock;
    logic                        multihLock;
    dacSampleT [dacChannels-1:0] legacyDac;
    dacSampleT [dacChannels-1:0] multihDac;
    demodModeT                   demodMode;
    dacSelectT [dacChannels-1:0] dacSelect;
    trellisOutT                  trellis;
    dataOutT                     dataOut;
    logic                        demodNLock;
    logic [dacChannels-1:0]      dacSync;
    dacWordT [dacChannels-1:0]   dacData;
    logic                        coreReset;
    logic                        rebootReq;
    logic [23:0]                 rebootAddr;

    integer  seed = 32'hed910b35;
    stimRowT rowTable [numRows];
    int      edges;
    int      highCycles;
    busDataT rdWord;
    busDataT randWord;

    tbClockGen i_tbClockGen (
        .clk            (clk),
        .clockCounterEn (clockCounterEn)
    );

    demodTop i_demodTop (.*);

    // ********************
    // Failure and compares
    // ********************
    task automatic reportFailure(input string reason);
        $display("%s", reason);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic trellisCheck(input string name, input trellisOutT exp, input trellisOutT act);
        if (act !== exp)
            reportFailure($sformatf("FAILED %s expected %h actual %h", name, exp, act));
    endtask

    task automatic dataOutCheck(input string name, input dataOutT exp, input dataOutT act);
        if (act !== exp)
            reportFailure($sformatf("FAILED %s expected %h actual %h", name, exp, act));
    endtask

    task automatic dacWordCheck(input string name, input dacWordT exp, input dacWordT act);
        if (act !== exp)
            reportFailure($sformatf("FAILED %s expected %h actual %h", name, exp, act));
    endtask

    task automatic busWordCheck(input string name, input busDataT exp, input busDataT act);
        if (act !== exp)
            reportFailure($sformatf("FAILED %s expected %h actual %h", name, exp, act));
    endtask

    task automatic modeCheck(input string name, input demodModeT exp, input demodModeT act);
        if (act !== exp)
            reportFailure($sformatf("FAILED %s expected %0d actual %0d", name, exp, act));
    endtask

    task automatic bitCheck(input string name, input logic exp, input logic act);
        if (act !== exp)
            reportFailure($sformatf("FAILED %s expected %b actual %b", name, exp, act));
    endtask

    task automatic countCheck(input string name, input int exp, input int act);
        if (act != exp)
            reportFailure($sformatf("FAILED %s expected %0d actual %0d", name, exp, act));
    endtask

    // ********************
    // Bus access
    // ********************
    task automatic writeReg(input busAddrT addr, input busDataT data);
        busAddr   = addr;
        busWrData = data;
        busWr     = 1'b1;
        @(posedge clk);
        #1;
        busWr = 1'b0;
    endtask

    // Samples one edge later, so a pending snapshot has landed
    task automatic readReg(input busAddrT addr, output busDataT data);
        busAddr = addr;
        @(posedge clk);
        #1;
        data = busRdData;
    endtask

    // ********************
    // Reference model
    // ********************
    function automatic trellisOutT routeTrellis(demodModeT mode, legacySymT leg, multihSymT mh);
        trellisOutT t;
        if (mode == ModeMultih) begin
            t = mh;
        end else begin
            t = {leg.symEn, leg.sym2xEn, leg.iSym, leg.qSym};
        end
        return t;
    endfunction

    function automatic dataOutT routeData(demodModeT mode, legacySymT leg);
        dataOutT d;
        d = {leg.iBit, leg.qBit, leg.symEn, leg.sym2xEn};
        case (mode)
            ModeFm, ModeFsk2:      d.iData = ~leg.iBit;
            ModeAqpsk, ModeAuqpsk: d.qData = leg.auBit;
            default:               d.iData = leg.iBit;
        endcase
        return d;
    endfunction

    function automatic dacSampleT pickDacSource(demodModeT mode, dacSampleT leg, dacSampleT mh);
        dacSampleT s;
        if (mode == ModeMultih && mh.en) begin
            s = mh;
        end else begin
            s = leg;
        end
        return s;
    endfunction

    // Pin words carry over from row to row while sync stays low
    task automatic buildTable();
        logic [63:0] bits;
        dacSampleT   src;
        dacWordT     pins [dacChannels];
        stimRowT     row;
        for (int ch = 0; ch < dacChannels; ch++) begin
            pins[ch] = '0;
        end
        for (int r = 0; r < numRows; r++) begin
            row.mode        = demodModeT'(5'(r % 10));
            bits            = {$random(seed), $random(seed)};
            row.legacy      = bits[59:0];
            bits            = {$random(seed), $random(seed)};
            row.multih      = bits[37:0];
            row.carrierLock = bits[40];
            row.multihLock  = bits[41];
            for (int ch = 0; ch < dacChannels; ch++) begin
                bits[31:0]                = $random(seed);
                row.legacyDac[ch]         = bits[19:0];
                row.legacyDac[ch].en      = 1'b1;
                bits[31:0]                = $random(seed);
                row.multihDac[ch]         = bits[19:0];
                if (row.mode == ModeMultih) begin
                    row.multihDac[ch].en = 1'((r / 10 + ch) % 2);
                end
                src = pickDacSource(row.mode, row.legacyDac[ch], row.multihDac[ch]);
                row.expSync[ch] = src.sync;
                if (src.sync) begin
                    pins[ch] = src.data[17:4];
                end
                row.expPins[ch] = pins[ch];
            end
            row.expTrellis = routeTrellis(row.mode, row.legacy, row.multih);
            row.expData    = routeData(row.mode, row.legacy);
            row.expNLock   = (row.mode == ModeMultih) ? ~row.multihLock : ~row.carrierLock;
            rowTable[r]    = row;
        end
    endtask

    initial begin
        busAddr     = '0;
        busWrData   = '0;
        busWr       = 1'b0;
        legacy      = '0;
        multih      = '0;
        carrierLock = 1'b0;
        multihLock  = 1'b0;
        legacyDac   = '0;
        multihDac   = '0;
        buildTable();

        edges = 0;
        while (clockCounterEn !== 1'b0) begin
            if (edges == waitLimit) reportFailure("Reset was never released");
            @(posedge clk);
            edges++;
        end
        @(posedge clk);
        #1;

        // Identification and read-back registers
        bitCheck("coreReset after reset", 1'b0, coreReset);
        dataOutCheck("dataOut after reset", '0, dataOut);
        modeCheck("mode port after reset", ModeAm, demodMode);
        readReg(AddrVersion, rdWord);
        busWordCheck("version", {verNumber, 16'h0}, rdWord);
        readReg(AddrType, rdWord);
        busWordCheck("image type", {16'h0, imageType}, rdWord);
        readReg(8'h20, rdWord);
        busWordCheck("unmapped read", '0, rdWord);
        readReg(AddrMode, rdWord);
        busWordCheck("mode after reset", {27'h0, ModeAm}, rdWord);
        writeReg(AddrMode, {27'h0, ModeQpsk});
        readReg(AddrMode, rdWord);
        busWordCheck("mode read-back", {27'h0, ModeQpsk}, rdWord);
        randWord = $random(seed);
        writeReg(AddrDacSelect, randWord);
        readReg(AddrDacSelect, rdWord);
        busWordCheck("dac select read-back", {20'h0, randWord[11:0]}, rdWord);
        busWordCheck("dac select port", {20'h0, randWord[11:0]}, {20'h0, dacSelect});

        // Restart, then snapshot n edges later
        for (int n = 1; n <= 9; n += 8) begin
            writeReg(AddrClock, '0);
            repeat (n - 1) begin
                @(posedge clk);
                #1;
            end
            writeReg(AddrSnap, '0);
            readReg(AddrClock, rdWord);
            busWordCheck($sformatf("snapshot after %0d edges", n), busDataT'(n - 1), rdWord);
        end

        // ********************
        // Routing and DAC table
        // ********************
        for (int r = 0; r < numRows; r++) begin
            writeReg(AddrMode, {27'h0, rowTable[r].mode});
            modeCheck($sformatf("row %0d demodMode", r), rowTable[r].mode, demodMode);
            legacy      = rowTable[r].legacy;
            multih      = rowTable[r].multih;
            carrierLock = rowTable[r].carrierLock;
            multihLock  = rowTable[r].multihLock;
            legacyDac   = rowTable[r].legacyDac;
            multihDac   = rowTable[r].multihDac;
            #1;
            bitCheck($sformatf("row %0d demodNLock", r), rowTable[r].expNLock, demodNLock);
            @(posedge clk);
            #1;
            trellisCheck($sformatf("row %0d trellis", r), rowTable[r].expTrellis, trellis);
            dataOutCheck($sformatf("row %0d dataOut", r), rowTable[r].expData, dataOut);
            for (int ch = 0; ch < dacChannels; ch++) begin
                bitCheck($sformatf("row %0d dacSync %0d", r, ch),
                         rowTable[r].expSync[ch], dacSync[ch]);
            end
            @(posedge clk);
            #1;
            for (int ch = 0; ch < dacChannels; ch++) begin
                dacWordCheck($sformatf("row %0d dacData %0d", r, ch),
                             rowTable[r].expPins[ch], dacData[ch]);
            end
        end

        // Soft reset with busy outputs
        writeReg(AddrMode, {27'h0, ModeAm});
        legacy    = '1;
        multihDac = '0;
        legacyDac = '1;
        repeat (2) begin
            @(posedge clk);
            #1;
        end
        dataOutCheck("dataOut before soft reset", 4'hF, dataOut);
        dacWordCheck("dacData before soft reset", 14'h3FFF, dacData[0]);
        writeReg(AddrReset, '0);
        edges = 0;
        while (!coreReset) begin
            if (edges == waitLimit) reportFailure("coreReset never rose after the reset write");
            @(posedge clk);
            #1;
            edges++;
        end
        countCheck("coreReset delay", 2, edges);
        highCycles = 0;
        while (coreReset) begin
            if (highCycles == waitLimit) reportFailure("coreReset stayed high too long");
            highCycles++;
            @(posedge clk);
            #1;
        end
        countCheck("coreReset length", resetCycles, highCycles);
        dataOutCheck("dataOut after soft reset", '0, dataOut);
        trellisCheck("trellis after soft reset", '0, trellis);
        for (int ch = 0; ch < dacChannels; ch++) begin
            dacWordCheck($sformatf("dacData %0d after soft reset", ch), '0, dacData[ch]);
        end

        // Reboot request
        randWord = $random(seed);
        writeReg(AddrRebootAddr, randWord);
        bitCheck("rebootReq pulse", 1'b1, rebootReq);
        busWordCheck("rebootAddr", {8'h0, randWord[23:0]}, {8'h0, rebootAddr});
        @(posedge clk);
        #1;
        bitCheck("rebootReq after pulse", 1'b0, rebootReq);

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

/* tbClockGen.sv */
/*
 * Testbench clock and reset source.
 * 4 ns clock, reset held high for the first resetClocks edges.
 */

`timescale 1ns/1ns

module tbClockGen #(
    parameter int resetClocks = 5
) (
    output logic clk,
    output logic clockCounterEn
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Release just after an edge so the DUT sees a clean first cycle
    initial begin
        clockCounterEn = 1'b1;
        repeat (resetClocks) @(posedge clk);
        #1 clockCounterEn = 1'b0;
    end

endmodule

/* demodTop.sv */
/*
 * Glue top level of the multi-mode demodulator board.
 * Register file, cycle counter, soft reset, symbol routing and DAC outputs.
 */

`timescale 1ns/1ns

module demodTop (
    input  logic                                            clk,
    input  logic                                            clockCounterEn,
    // Processor bus
    input  demodPkg::busAddrT                               busAddr,
    input  demodPkg::busDataT                               busWrData,
    input  logic                                            busWr,
    output demodPkg::busDataT                               busRdData,
    // Demod core and multi-h loop
    input  demodPkg::legacySymT                             legacy,
    input  demodPkg::multihSymT                             multih,
    input  logic                                            carrierLock,
    input  logic                                            multihLock,
    input  demodPkg::dacSampleT [demodPkg::dacChannels-1:0] legacyDac,
    input  demodPkg::dacSampleT [demodPkg::dacChannels-1:0] multihDac,
    // Outputs
    output demodPkg::demodModeT                             demodMode,
    output demodPkg::dacSelectT [demodPkg::dacChannels-1:0] dacSelect,
    output demodPkg::trellisOutT                            trellis,
    output demodPkg::dataOutT                               dataOut,
    output logic                                            demodNLock,
    output logic [demodPkg::dacChannels-1:0]                dacSync,
    output demodPkg::dacWordT [demodPkg::dacChannels-1:0]   dacData,
    output logic                                            coreReset,
    output logic                                            rebootReq,
    output logic [23:0]                                     rebootAddr
);

    import demodPkg::*;

    busDataT snapshot;
    logic    restartStrobe;
    logic    snapStrobe;
    logic    softResetReq;
    logic    datapathClear;

    // Datapath clears on board reset as well as soft reset
    assign datapathClear = clockCounterEn | coreReset;

    // ********************
    // Control
    // ********************
    demodRegs i_demodRegs (
        .clk            (clk),
        .clockCounterEn (clockCounterEn),
        .busAddr        (busAddr),
        .busWrData      (busWrData),
        .busWr          (busWr),
        .snapshot       (snapshot),
        .busRdData      (busRdData),
        .restartStrobe  (restartStrobe),
        .snapStrobe     (snapStrobe),
        .softResetReq   (softResetReq),
        .rebootReq      (rebootReq),
        .rebootAddr     (rebootAddr),
        .demodMode      (demodMode),
        .dacSelect      (dacSelect)
    );

    cycleCounter i_cycleCounter (
        .clk            (clk),
        .clockCounterEn (clockCounterEn),
        .restartStrobe  (restartStrobe),
        .snapStrobe     (snapStrobe),
        .snapshot       (snapshot)
    );

    resetSequencer i_resetSequencer (
        .clk            (clk),
        .clockCounterEn (clockCounterEn),
        .softResetReq   (softResetReq),
        .coreReset      (coreReset)
    );

    // ********************
    // Datapath
    // ********************
    symbolRouter i_symbolRouter (
        .clk         (clk),
        .coreReset   (datapathClear),
        .demodMode   (demodMode),
        .legacy      (legacy),
        .multih      (multih),
        .carrierLock (carrierLock),
        .multihLock  (multihLock),
        .trellis     (trellis),
        .dataOut     (dataOut),
        .demodNLock  (demodNLock)
    );

    dacOutputStage i_dacOutputStage (
        .clk       (clk),
        .coreReset (datapathClear),
        .demodMode (demodMode),
        .legacyDac (legacyDac),
        .multihDac (multihDac),
        .dacSync   (dacSync),
        .dacData   (dacData)
    );

endmodule

/* dacOutputStage.sv */
/*
 * Three DAC test-point channels. Each picks the multi-h or the legacy
 * sample, registers it, then loads bits 17:4 onto the pins on sync.
 */

`timescale 1ns/1ns

module dacOutputStage (
    input  logic                                           clk,
    input  logic                                           coreReset,
    input  demodPkg::demodModeT                            demodMode,
    input  demodPkg::dacSampleT [demodPkg::dacChannels-1:0] legacyDac,
    input  demodPkg::dacSampleT [demodPkg::dacChannels-1:0] multihDac,
    output logic [demodPkg::dacChannels-1:0]               dacSync,
    output demodPkg::dacWordT [demodPkg::dacChannels-1:0]   dacData
);

    import demodPkg::*;

    logic multihMode;

    assign multihMode = (demodMode == ModeMultih);

    for (genvar ch = 0; ch < dacChannels; ch++) begin : gChannel
        logic      useMultih;
        dacSampleT source;
        sampleT    sampleReg;

        // Multi-h loop only drives a channel while it flags it enabled
        assign useMultih = multihMode && multihDac[ch].en;
        assign source    = useMultih ? multihDac[ch] : legacyDac[ch];

        // ********************
        // Stage 1, source select
        // ********************
        always_ff @(posedge clk or posedge coreReset) begin
            if (coreReset) begin
                sampleReg   <= '0;
                dacSync[ch] <= 1'b0;
            end else begin
                sampleReg   <= source.data;
                dacSync[ch] <= source.sync;
            end
        end

        // Stage 2, pin word holds between syncs
        always_ff @(posedge clk or posedge coreReset) begin
            if (coreReset) begin
                dacData[ch] <= '0;
            end else if (dacSync[ch]) begin
                dacData[ch] <= sampleReg[17:4];
            end
        end

        assert property (@(posedge clk) disable iff (coreReset)
            $changed(dacData[ch]) |-> $past(dacSync[ch]))
            else $error("DAC channel %0d changed without sync", ch);
    end

endmodule

/* symbolRouter.sv */
/*
 * Routes trellis symbols and data bits by demod mode.
 * Multi-h mode takes the carrier loop symbols, all others the legacy path.
 * Outputs are registered one clock after the inputs; the lock is not.
 */

`timescale 1ns/1ns

module symbolRouter (
    input  logic                 clk,
    input  logic                 coreReset,
    input  demodPkg::demodModeT  demodMode,
    input  demodPkg::legacySymT  legacy,
    input  demodPkg::multihSymT  multih,
    input  logic                 carrierLock,
    input  logic                 multihLock,
    output demodPkg::trellisOutT trellis,
    output demodPkg::dataOutT    dataOut,
    output logic                 demodNLock
);

    import demodPkg::*;

    logic multihMode;
    logic fmModes;
    logic aModes;

    assign multihMode = (demodMode == ModeMultih);
    assign fmModes    = (demodMode == ModeFm) || (demodMode == ModeFsk2);
    assign aModes     = (demodMode == ModeAqpsk) || (demodMode == ModeAuqpsk);

    // ********************
    // Trellis symbols
    // ********************
    always_ff @(posedge clk or posedge coreReset) begin
        if (coreReset) begin
            trellis <= '0;
        end else if (multihMode) begin
            trellis <= multih;
        end else begin
            trellis.symEn   <= legacy.symEn;
            trellis.sym2xEn <= legacy.sym2xEn;
            trellis.iSym    <= legacy.iSym;
            trellis.qSym    <= legacy.qSym;
        end
    end

    // ********************
    // Data bits
    // ********************
    always_ff @(posedge clk or posedge coreReset) begin
        if (coreReset) begin
            dataOut <= '0;
        end else begin
            // FM style demods deliver the bit inverted
            dataOut.iData   <= fmModes ? ~legacy.iBit : legacy.iBit;
            // Asymmetric modes carry Q on the unbalanced bit
            dataOut.qData   <= aModes ? legacy.auBit : legacy.qBit;
            dataOut.symEn   <= legacy.symEn;
            dataOut.sym2xEn <= legacy.sym2xEn;
        end
    end

    assign demodNLock = multihMode ? ~multihLock : ~carrierLock;

endmodule

/* cycleCounter.sv */
/*
 * Free running 32-bit clock counter.
 * restartStrobe clears it, snapStrobe copies it to the snapshot.
 */

`timescale 1ns/1ns

module cycleCounter (
    input  logic              clk,
    input  logic              clockCounterEn,
    input  logic              restartStrobe,
    input  logic              snapStrobe,
    output demodPkg::busDataT snapshot
);

    import demodPkg::*;

    busDataT count;

    always_ff @(posedge clk or posedge clockCounterEn) begin
        if (clockCounterEn) begin
            count <= '0;
        end else if (restartStrobe) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

    // Held for the processor to read at leisure
    always_ff @(posedge clk or posedge clockCounterEn) begin
        if (clockCounterEn) begin
            snapshot <= '0;
        end else if (snapStrobe) begin
            snapshot <= count;
        end
    end

endmodule

/* resetSequencer.sv */
/*
 * Stretches a one-clock soft reset request into a core reset pulse
 * of resetCycles clocks, after one clock of synchronization.
 */

`timescale 1ns/1ns

module resetSequencer (
    input  logic clk,
    input  logic clockCounterEn,
    input  logic softResetReq,
    output logic coreReset
);

    import demodPkg::*;

    typedef enum logic [1:0] {
        Idle,
        Sync,
        Hold
    } seqStateT;

    seqStateT                   state;
    logic [resetCountWidth-1:0] holdCount;

    always_ff @(posedge clk or posedge clockCounterEn) begin
        if (clockCounterEn) begin
            state     <= Idle;
            holdCount <= '0;
            coreReset <= 1'b0;
        end else begin
            case (state)
                Idle: begin
                    if (softResetReq) begin
                        state <= Sync;
                    end
                end
                Sync: begin
                    state     <= Hold;
                    holdCount <= resetCountWidth'(resetCycles - 1);
                    coreReset <= 1'b1;
                end
                Hold: begin
                    if (holdCount == '0) begin
                        state     <= Idle;
                        coreReset <= 1'b0;
                    end else begin
                        holdCount <= holdCount - 1'b1;
                    end
                end
                default: state <= Idle;
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (clockCounterEn)
        (state == Idle) |-> !coreReset)
        else $error("core reset active while sequencer idle");

endmodule

/* demodRegs.sv */
/*
 * Processor register file for the board level registers.
 * Writes are sampled on busWr; reads are combinational from busAddr.
 * Control writes come out as one-clock strobes.
 */

`timescale 1ns/1ns

module demodRegs (
    input  logic                                              clk,
    input  logic                                              clockCounterEn,
    input  demodPkg::busAddrT                                 busAddr,
    input  demodPkg::busDataT                                 busWrData,
    input  logic                                              busWr,
    input  demodPkg::busDataT                                 snapshot,
    output demodPkg::busDataT                                 busRdData,
    output logic                                              restartStrobe,
    output logic                                              snapStrobe,
    output logic                                              softResetReq,
    output logic                                              rebootReq,
    output logic [23:0]                                       rebootAddr,
    output demodPkg::demodModeT                               demodMode,
    output demodPkg::dacSelectT [demodPkg::dacChannels-1:0]   dacSelect
);

    import demodPkg::*;

    regAddrT regAddr;

    assign regAddr = regAddrT'(busAddr);

    // ********************
    // Write decode
    // ********************
    always_ff @(posedge clk or posedge clockCounterEn) begin
        if (clockCounterEn) begin
            restartStrobe <= 1'b0;
            snapStrobe    <= 1'b0;
            softResetReq  <= 1'b0;
            rebootReq     <= 1'b0;
            demodMode     <= ModeAm;
            dacSelect     <= '0;
        end else begin
            restartStrobe <= busWr && (regAddr == AddrClock);
            snapStrobe    <= busWr && (regAddr == AddrSnap);
            softResetReq  <= busWr && (regAddr == AddrReset);
            rebootReq     <= busWr && (regAddr == AddrRebootAddr);
            if (busWr && (regAddr == AddrMode)) begin
                demodMode <= demodModeT'(busWrData[4:0]);
            end
            if (busWr && (regAddr == AddrDacSelect)) begin
                dacSelect <= busWrData[4*dacChannels-1:0];
            end
        end
    end

    // Boot address goes out with the reboot pulse
    always_ff @(posedge clk or posedge clockCounterEn) begin
        if (clockCounterEn) begin
            rebootAddr <= '0;
        end else if (busWr && (regAddr == AddrRebootAddr)) begin
            rebootAddr <= busWrData[23:0];
        end
    end

    // ********************
    // Read mux
    // ********************
    always_comb begin
        case (regAddr)
            AddrVersion:   busRdData = {verNumber, 16'h0};
            AddrType:      busRdData = {16'h0, imageType};
            AddrClock:     busRdData = snapshot;
            AddrMode:      busRdData = {27'h0, demodMode};
            AddrDacSelect: busRdData = {{(32 - 4*dacChannels){1'b0}}, dacSelect};
            default:       busRdData = '0;
        endcase
    end

    // Only one control write can land per clock
    assert property (@(posedge clk) disable iff (clockCounterEn)
        $onehot0({restartStrobe, snapStrobe, softResetReq, rebootReq}))
        else $error("more than one control strobe active");

endmodule

/* demodPkg.sv */
/*
 * Shared types and constants for the demodulator glue logic.
 * Compile first; modules import it inside their bodies.
 */

package demodPkg;

    // ********************
    // Widths and base types
    // ********************
    typedef logic [7:0]         busAddrT;
    typedef logic [31:0]        busDataT;
    typedef logic signed [17:0] sampleT;
    typedef logic [13:0]        dacWordT;
    typedef logic [3:0]         dacSelectT;

    // Board identification
    localparam logic [15:0] verNumber = 16'h0188;
    localparam logic [15:0] imageType = 16'h0003;

    // Soft reset length in clocks
    localparam int resetCycles = 5;
    localparam int resetCountWidth = $clog2(resetCycles + 1);

    localparam int dacChannels = 3;

    // ********************
    // Register map
    // ********************
    typedef enum busAddrT {
        AddrVersion    = 8'h00,
        AddrType       = 8'h01,
        AddrClock      = 8'h02,
        AddrSnap       = 8'h03,
        AddrReset      = 8'h04,
        AddrRebootAddr = 8'h05,
        AddrMode       = 8'h06,
        AddrDacSelect  = 8'h07
    } regAddrT;

    typedef enum logic [4:0] {
        ModeAm     = 5'd0,
        ModePm     = 5'd1,
        ModeFm     = 5'd2,
        ModeFsk2   = 5'd3,
        ModeBpsk   = 5'd4,
        ModeQpsk   = 5'd5,
        ModeOqpsk  = 5'd6,
        ModeAqpsk  = 5'd7,
        ModeAuqpsk = 5'd8,
        ModeMultih = 5'd9
    } demodModeT;

    // ********************
    // Streams
    // ********************
    typedef struct packed {
        logic   symEn;
        logic   sym2xEn;
        sampleT iSym;
        sampleT qSym;
        logic   iBit;
        logic   qBit;
        logic   auBit;
    } legacySymT;

    typedef struct packed {
        logic   symEn;
        logic   sym2xEn;
        sampleT iSym;
        sampleT qSym;
    } multihSymT;

    // Trellis decoder sees the same layout as the multi-h loop output
    typedef multihSymT trellisOutT;

    typedef struct packed {
        logic iData;
        logic qData;
        logic symEn;
        logic sym2xEn;
    } dataOutT;

    typedef struct packed {
        logic   sync;
        logic   en;
        sampleT data;
    } dacSampleT;

endpackage
